// File: Bender.yml
package:
  name: pktz

sources:
  - common/pktz_pkg.sv
  - hw/fifo/sync_fifo.sv
  - hw/ingress/sample_pairer.sv
  - hw/ingress/packet_timer.sv
  - hw/egress/frame_ctrl.sv
  - hw/pktz_top.sv
  - target: test
    files:
      - tb/tb_clock.sv
      - tb/pktz_tb.sv

// File: all.f
common/pktz_pkg.sv
hw/fifo/sync_fifo.sv
hw/ingress/sample_pairer.sv
hw/ingress/packet_timer.sv
hw/egress/frame_ctrl.sv
hw/pktz_top.sv
tb/tb_clock.sv
tb/pktz_tb.sv

// File: common/pktz_pkg.sv
/*
 Shared widths, field layout and enums of the packetizer.
 Samples are fixed at 16-bit I over 16-bit Q.
*/
package pktz_pkg;

   // ------------------------------
   // Stream and field widths
   // ------------------------------
   localparam int SAMPLE_W = 32;
   localparam int WORD_W   = 64;
   localparam int SIZE_W   = 14;
   localparam int TIME_W   = 64;
   localparam int BURST_W  = 48;
   localparam int FLOW_W   = 32;
   localparam int SEQ_W    = 8;
   localparam int INC_W    = 16;

   // Header plus time word, counted in 32-bit units
   localparam int HDR_WORDS32 = 4;

   // ------------------------------
   // Time FIFO entry layout
   // ------------------------------
   // EOB flag over size over timestamp
   localparam int TENTRY_W    = 1 + SIZE_W + TIME_W;
   localparam int TE_EOB_BIT  = TENTRY_W - 1;
   localparam int TE_SIZE_LSB = TIME_W;

   // FIFO depths as log2
   localparam int TIME_FIFO_DEPTH_LOG   = 4;
   localparam int SAMPLE_FIFO_DEPTH_LOG = 10;

   // Packet type field of the header word
   typedef enum logic [7:0] {
      INT16_COMPLEX     = 8'h10,
      INT16_COMPLEX_EOB = 8'h11
   } pkt_type_t;

   // Egress framer states
   typedef enum logic [1:0] {
      OUT_HEADER,
      OUT_TIME,
      OUT_SAMPLES,
      OUT_FLUSH
   } out_state_t;

   // Ingress pairing states
   typedef enum logic [1:0] {
      IN_IDLE,
      IN_PHASE1,
      IN_PHASE2
   } in_state_t;

endpackage

// File: hw/egress/frame_ctrl.sv
/*
 Egress framer: header, time word, then sample words up to the last bit.
 out_data holds while out_valid is high and out_ready low, given a steady flow_id.
*/
`timescale 1ns/10ps

module frame_ctrl (
   input  logic                          clk,
   input  logic                          rst,
   input  logic                          enable,
   input  logic [pktz_pkg::FLOW_W-1:0]   flow_id,
   input  logic [pktz_pkg::TENTRY_W-1:0] tfifo_data,
   input  logic                          tfifo_valid,
   output logic                          tfifo_ready,
   input  logic [pktz_pkg::WORD_W:0]     sfifo_data,
   input  logic                          sfifo_valid,
   output logic                          sfifo_ready,
   output logic [pktz_pkg::WORD_W-1:0]   out_data,
   output logic                          out_valid,
   output logic                          out_last,
   input  logic                          out_ready,
   output logic                          flush,
   input  logic                          ingress_idle,
   output logic                          idle
);

   import pktz_pkg::*;

   out_state_t       state;
   logic [SEQ_W-1:0] seq;
   pkt_type_t        hdr_type;
   logic             eob;
   logic             accept;

   assign eob      = tfifo_data[TE_EOB_BIT];
   assign hdr_type = eob ? INT16_COMPLEX_EOB : INT16_COMPLEX;
   assign accept   = out_valid && out_ready;

   // ------------------------------
   // Output FSM
   // ------------------------------
   always_ff @(posedge clk) begin
      if (rst) begin
         state <= OUT_FLUSH;
      end else begin
         case (state)
            OUT_HEADER:
               if (tfifo_valid && out_ready)
                  state <= OUT_TIME;
               else if (!tfifo_valid && !enable)
                  state <= OUT_FLUSH;
            OUT_TIME:
               if (tfifo_valid && out_ready)
                  state <= OUT_SAMPLES;
            // Stay until the word marked last is taken
            OUT_SAMPLES:
               if (sfifo_valid && sfifo_data[WORD_W] && out_ready)
                  state <= enable ? OUT_HEADER : OUT_FLUSH;
            OUT_FLUSH:
               if (enable)
                  state <= OUT_HEADER;
            default:
               state <= OUT_FLUSH;
         endcase
      end
   end

   // Trails the state by one cycle
   always_ff @(posedge clk) begin
      if (rst)
         flush <= 1'b1;
      else
         flush <= (state == OUT_FLUSH);
   end

   // ------------------------------
   // Sequence number
   // ------------------------------
   // Flush state is reached only while disabled
   always_ff @(posedge clk) begin
      if (rst || state == OUT_FLUSH)
         seq <= '0;
      else if (state == OUT_HEADER && eob && accept)
         seq <= '1;
      else if (accept && out_last)
         seq <= seq + 1'b1;
   end

   // ------------------------------
   // Word mux
   // ------------------------------
   always_comb begin
      out_data    = '0;
      out_valid   = 1'b0;
      out_last    = 1'b0;
      tfifo_ready = 1'b0;
      sfifo_ready = 1'b0;
      case (state)
         OUT_HEADER: begin
            out_data  = {hdr_type, seq, tfifo_data[TE_SIZE_LSB +: SIZE_W], 2'b00, flow_id};
            out_valid = tfifo_valid;
         end
         // Time entry popped with the time word
         OUT_TIME: begin
            out_data    = tfifo_data[TIME_W-1:0];
            out_valid   = tfifo_valid;
            tfifo_ready = out_ready;
         end
         OUT_SAMPLES: begin
            out_data    = sfifo_data[WORD_W-1:0];
            out_valid   = sfifo_valid;
            out_last    = sfifo_data[WORD_W];
            sfifo_ready = out_ready;
         end
         default: ;
      endcase
   end

   // Quiet once disabled and drained
   always_ff @(posedge clk) begin
      if (rst)
         idle <= 1'b1;
      else
         idle <= !enable && !out_valid && !tfifo_valid && ingress_idle;
   end

   a_out_stable: assert property (@(posedge clk) disable iff (rst)
      out_valid && !out_ready |=> out_valid && $stable(out_data));

endmodule

// File: hw/fifo/sync_fifo.sv
/*
 Single-clock FIFO, depth 2**DEPTH_LOG, with combinational read port.
 flush empties it like rst, and writes are refused while flush is high.
*/
`timescale 1ns/10ps

module sync_fifo #(
   parameter int WIDTH     = 8,
   parameter int DEPTH_LOG = 4
) (
   input  logic             clk,
   input  logic             rst,
   input  logic             flush,
   input  logic [WIDTH-1:0] wr_data,
   input  logic             wr_valid,
   output logic             wr_ready,
   output logic [WIDTH-1:0] rd_data,
   output logic             rd_valid,
   input  logic             rd_ready
);

   logic [WIDTH-1:0]     mem [2**DEPTH_LOG];
   logic [DEPTH_LOG-1:0] wr_ptr;
   logic [DEPTH_LOG-1:0] rd_ptr;
   logic [DEPTH_LOG:0]   count;
   logic                 wr_fire;
   logic                 rd_fire;

   // Top count bit set means completely full
   assign wr_ready = !flush && !count[DEPTH_LOG];
   assign rd_valid = (count != '0);
   assign rd_data  = mem[rd_ptr];

   assign wr_fire = wr_valid && wr_ready;
   assign rd_fire = rd_valid && rd_ready;

   // Pointers wrap on their own width
   always_ff @(posedge clk) begin
      if (rst || flush) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (wr_fire)
            wr_ptr <= wr_ptr + 1'b1;
         if (rd_fire)
            rd_ptr <= rd_ptr + 1'b1;
         if (wr_fire && !rd_fire)
            count <= count + 1'b1;
         else if (rd_fire && !wr_fire)
            count <= count - 1'b1;
      end
   end

   // Storage
   always_ff @(posedge clk) begin
      if (wr_fire)
         mem[wr_ptr] <= wr_data;
   end

   a_count_bound: assert property (@(posedge clk) disable iff (rst)
      count <= 2**DEPTH_LOG);

endmodule

// File: hw/ingress/packet_timer.sv
/*
 Burst counter and per-packet timestamp. burst_size of 0 means infinite.
 One time FIFO entry per packet, written on its last input beat.
*/
`timescale 1ns/10ps

module packet_timer (
   input  logic                          clk,
   input  logic                          rst,
   input  logic                          enable,
   input  logic                          beat,
   input  logic                          pkt_first,
   input  logic                          pkt_end,
   input  logic [pktz_pkg::SIZE_W-1:0]   pkt_count,
   input  logic [pktz_pkg::TIME_W-1:0]   start_time,
   input  logic [pktz_pkg::INC_W-1:0]    time_per_pkt,
   input  logic [pktz_pkg::BURST_W-1:0]  burst_size,
   output logic                          burst_last,
   output logic [pktz_pkg::TENTRY_W-1:0] tfifo_wr_data,
   output logic                          tfifo_wr_valid,
   output logic                          burst_idle
);

   import pktz_pkg::*;

   typedef enum logic {
      BURST_NEW,
      BURST_ACTIVE
   } burst_state_t;

   burst_state_t       burst_state;
   logic [BURST_W-1:0] burst_count;
   logic [TIME_W-1:0]  packet_time;
   logic [TIME_W-1:0]  next_time;
   logic [TIME_W-1:0]  entry_time;

   // Last sample of a finite burst
   assign burst_last = (burst_count <= BURST_W'(1)) && (burst_size != '0);
   assign burst_idle = (burst_state == BURST_NEW);

   // ------------------------------
   // Burst tracking
   // ------------------------------
   always_ff @(posedge clk) begin
      if (rst || !enable) begin
         burst_state <= BURST_NEW;
         burst_count <= burst_size;
      end else if (beat) begin
         if (burst_size != '0)
            burst_count <= burst_count - 1'b1;
         // Reload for the next burst
         if (burst_count == BURST_W'(1)) begin
            burst_state <= BURST_NEW;
            burst_count <= burst_size;
         end else begin
            burst_state <= BURST_ACTIVE;
         end
      end
   end

   // ------------------------------
   // Packet timestamp
   // ------------------------------
   assign next_time = (burst_state == BURST_NEW) ? start_time
                                                 : packet_time + TIME_W'(time_per_pkt);

   always_ff @(posedge clk) begin
      if (pkt_first)
         packet_time <= next_time;
   end

   // One-sample packet starts and ends on the same beat
   assign entry_time = pkt_first ? next_time : packet_time;

   assign tfifo_wr_valid = pkt_end;
   assign tfifo_wr_data  = {burst_last, pkt_count + SIZE_W'(HDR_WORDS32), entry_time};

endmodule

// File: hw/ingress/sample_pairer.sv
/*
 Pairs input samples into 64-bit words and marks packet boundaries.
 packet_size must be at least 1. pkt_count equals 1 only while idle.
*/
`timescale 1ns/10ps

module sample_pairer (
   input  logic                          clk,
   input  logic                          rst,
   input  logic                          enable,
   input  logic                          beat,
   input  logic [pktz_pkg::SAMPLE_W-1:0] in_data,
   input  logic [pktz_pkg::SIZE_W-1:0]   packet_size,
   input  logic                          burst_last,
   output logic                          pkt_first,
   output logic                          pkt_end,
   output logic [pktz_pkg::SIZE_W-1:0]   pkt_count,
   output logic [pktz_pkg::WORD_W:0]     sfifo_wr_data,
   output logic                          sfifo_wr_valid
);

   import pktz_pkg::*;

   in_state_t           state;
   logic [SIZE_W-1:0]   count;
   logic [SAMPLE_W-1:0] hold;
   logic                end_cond;
   logic                odd_end;

   // ------------------------------
   // Packet boundary decode
   // ------------------------------
   // Burst end cuts the packet short
   assign end_cond  = (count >= packet_size) || burst_last;
   assign pkt_first = beat && (state == IN_IDLE);
   assign pkt_end   = beat && end_cond;
   assign pkt_count = count;

   // Odd count on the ending beat leaves a lone sample
   assign odd_end = pkt_end && count[0];

   // ------------------------------
   // Sample FIFO write
   // ------------------------------
   assign sfifo_wr_valid = (beat && (state == IN_PHASE2)) || odd_end;

   // Earlier sample on top, lone sample duplicated in both halves
   assign sfifo_wr_data = {pkt_end, (odd_end ? in_data : hold), in_data};

   always_ff @(posedge clk) begin
      if (beat)
         hold <= in_data;
   end

   // ------------------------------
   // Pairing FSM
   // ------------------------------
   // Count preloaded to 1 for the sample in flight
   always_ff @(posedge clk) begin
      if (rst || !enable) begin
         state <= IN_IDLE;
         count <= SIZE_W'(1);
      end else if (beat) begin
         if (end_cond) begin
            state <= IN_IDLE;
            count <= SIZE_W'(1);
         end else begin
            count <= count + 1'b1;
            case (state)
               IN_IDLE:   state <= IN_PHASE2;
               IN_PHASE1: state <= IN_PHASE2;
               IN_PHASE2: state <= IN_PHASE1;
               default:   state <= IN_IDLE;
            endcase
         end
      end
   end

   // Pair and lone writes rely on an even count in phase 2 only
   a_phase_parity: assert property (@(posedge clk) disable iff (rst)
      (state == IN_PHASE2) == !count[0]);

endmodule

// File: hw/pktz_top.sv
/*
 Packetizer top: ingress pairing and timing, two FIFOs, egress framer.
 Output has no buffering of its own beyond the FIFOs.
*/
`timescale 1ns/10ps

module pktz_top (
   input  logic                         clk,
   input  logic                         rst,
   input  logic [pktz_pkg::SAMPLE_W-1:0] in_data,
   input  logic                         in_valid,
   output logic                         in_ready,
   output logic [pktz_pkg::WORD_W-1:0]  out_data,
   output logic                         out_valid,
   output logic                         out_last,
   input  logic                         out_ready,
   input  logic                         enable,
   input  logic [pktz_pkg::TIME_W-1:0]  start_time,
   input  logic [pktz_pkg::SIZE_W-1:0]  packet_size,
   input  logic [pktz_pkg::FLOW_W-1:0]  flow_id,
   input  logic [pktz_pkg::INC_W-1:0]   time_per_pkt,
   input  logic [pktz_pkg::BURST_W-1:0] burst_size,
   output logic                         idle
);

   import pktz_pkg::*;

   logic                beat;
   logic                burst_last;
   logic                pkt_first;
   logic                pkt_end;
   logic [SIZE_W-1:0]   pkt_count;
   logic                burst_idle;
   logic                ingress_idle;
   logic                flush;

   logic [TENTRY_W-1:0] tfifo_wr_data;
   logic                tfifo_wr_valid;
   logic                tfifo_wr_ready;
   logic [TENTRY_W-1:0] tfifo_rd_data;
   logic                tfifo_rd_valid;
   logic                tfifo_rd_ready;

   logic [WORD_W:0]     sfifo_wr_data;
   logic                sfifo_wr_valid;
   logic                sfifo_wr_ready;
   logic [WORD_W:0]     sfifo_rd_data;
   logic                sfifo_rd_valid;
   logic                sfifo_rd_ready;

   // ------------------------------
   // Ingress handshake
   // ------------------------------
   assign in_ready = sfifo_wr_ready && tfifo_wr_ready && enable;
   assign beat     = in_valid && in_ready;

   // Pairer count sits at 1 only in its idle state
   assign ingress_idle = (pkt_count == SIZE_W'(1)) && burst_idle;

   sample_pairer u_pairer (
      .clk            (clk),
      .rst            (rst),
      .enable         (enable),
      .beat           (beat),
      .in_data        (in_data),
      .packet_size    (packet_size),
      .burst_last     (burst_last),
      .pkt_first      (pkt_first),
      .pkt_end        (pkt_end),
      .pkt_count      (pkt_count),
      .sfifo_wr_data  (sfifo_wr_data),
      .sfifo_wr_valid (sfifo_wr_valid)
   );

   packet_timer u_timer (
      .clk            (clk),
      .rst            (rst),
      .enable         (enable),
      .beat           (beat),
      .pkt_first      (pkt_first),
      .pkt_end        (pkt_end),
      .pkt_count      (pkt_count),
      .start_time     (start_time),
      .time_per_pkt   (time_per_pkt),
      .burst_size     (burst_size),
      .burst_last     (burst_last),
      .tfifo_wr_data  (tfifo_wr_data),
      .tfifo_wr_valid (tfifo_wr_valid),
      .burst_idle     (burst_idle)
   );

   // ------------------------------
   // Decoupling FIFOs
   // ------------------------------
   sync_fifo #(
      .WIDTH     (TENTRY_W),
      .DEPTH_LOG (TIME_FIFO_DEPTH_LOG)
   ) u_time_fifo (
      .clk      (clk),
      .rst      (rst),
      .flush    (flush),
      .wr_data  (tfifo_wr_data),
      .wr_valid (tfifo_wr_valid),
      .wr_ready (tfifo_wr_ready),
      .rd_data  (tfifo_rd_data),
      .rd_valid (tfifo_rd_valid),
      .rd_ready (tfifo_rd_ready)
   );

   sync_fifo #(
      .WIDTH     (WORD_W + 1),
      .DEPTH_LOG (SAMPLE_FIFO_DEPTH_LOG)
   ) u_sample_fifo (
      .clk      (clk),
      .rst      (rst),
      .flush    (flush),
      .wr_data  (sfifo_wr_data),
      .wr_valid (sfifo_wr_valid),
      .wr_ready (sfifo_wr_ready),
      .rd_data  (sfifo_rd_data),
      .rd_valid (sfifo_rd_valid),
      .rd_ready (sfifo_rd_ready)
   );

   frame_ctrl u_framer (
      .clk          (clk),
      .rst          (rst),
      .enable       (enable),
      .flow_id      (flow_id),
      .tfifo_data   (tfifo_rd_data),
      .tfifo_valid  (tfifo_rd_valid),
      .tfifo_ready  (tfifo_rd_ready),
      .sfifo_data   (sfifo_rd_data),
      .sfifo_valid  (sfifo_rd_valid),
      .sfifo_ready  (sfifo_rd_ready),
      .out_data     (out_data),
      .out_valid    (out_valid),
      .out_last     (out_last),
      .out_ready    (out_ready),
      .flush        (flush),
      .ingress_idle (ingress_idle),
      .idle         (idle)
   );

endmodule

// File: tb/pktz_tb.sv
/*
 Directed tests of the packetizer against a model of the packet format.
 Each test starts disabled and sends whole packets, so seq starts at 0.
*/
`timescale 1ns/10ps

module pktz_tb;

   import pktz_pkg::*;

   // Timeout is four times the sum of these per-test cycle budgets
   localparam int LEN_RESET        = 5;
   localparam int LEN_EVEN         = 40;
   localparam int LEN_ODD          = 50;
   localparam int LEN_BURST        = 70;
   localparam int LEN_BACKPRESSURE = 200;
   localparam int LEN_DISABLE      = 110;
   localparam int TIMEOUT_CYCLES   = 4 * (LEN_RESET + LEN_EVEN + LEN_ODD + LEN_BURST
                                          + LEN_BACKPRESSURE + LEN_DISABLE);
   // Quiet cycles watched after the last expected word
   localparam int DRAIN_CYCLES     = 16;

   logic                clk;
   logic                rst;
   logic [SAMPLE_W-1:0] in_data;
   logic                in_valid;
   logic                in_ready;
   logic [WORD_W-1:0]   out_data;
   logic                out_valid;
   logic                out_last;
   logic                out_ready;
   logic                enable;
   logic [TIME_W-1:0]   start_time;
   logic [SIZE_W-1:0]   packet_size;
   logic [FLOW_W-1:0]   flow_id;
   logic [INC_W-1:0]    time_per_pkt;
   logic [BURST_W-1:0]  burst_size;
   logic                idle;

   // Expected words as {last, data}, and the samples of the current test
   logic [WORD_W:0]     exp_q [$];
   logic [SAMPLE_W-1:0] smp_q [$];
   string               test_name;
   int                  test_errors;
   int                  errors;
   int                  checks;
   int                  tests_run;
   int                  tests_failed;
   int                  cycles;
   int                  in_density;
   int                  out_density;

   tb_clock u_clock (
      .clk (clk),
      .rst (rst)
   );

   pktz_top u_dut (
      .clk          (clk),
      .rst          (rst),
      .in_data      (in_data),
      .in_valid     (in_valid),
      .in_ready     (in_ready),
      .out_data     (out_data),
      .out_valid    (out_valid),
      .out_last     (out_last),
      .out_ready    (out_ready),
      .enable       (enable),
      .start_time   (start_time),
      .packet_size  (packet_size),
      .flow_id      (flow_id),
      .time_per_pkt (time_per_pkt),
      .burst_size   (burst_size),
      .idle         (idle)
   );

   // ------------------------------
   // Packet format model
   // ------------------------------
   // Enable held high over all of smp_q
   task automatic build_expected();
      int               pos;
      int               len;
      int               rem;
      int               i;
      logic [SEQ_W-1:0] seq;
      logic [TIME_W-1:0] t;
      logic             eob;
      logic             new_burst;
      logic             last_word;
      pkt_type_t        ptype;
      exp_q.delete();
      pos = 0;
      seq = '0;
      t = start_time;
      rem = int'(burst_size);
      new_burst = 1'b1;
      while (pos < smp_q.size()) begin
         len = int'(packet_size);
         // Burst remainder gives a short packet
         if (burst_size != 0 && rem < len)
            len = rem;
         eob = (burst_size != 0) && (rem == len);
         t = new_burst ? start_time : t + TIME_W'(time_per_pkt);
         ptype = eob ? INT16_COMPLEX_EOB : INT16_COMPLEX;
         exp_q.push_back({1'b0, ptype, seq, SIZE_W'(len + HDR_WORDS32), 2'b00, flow_id});
         exp_q.push_back({1'b0, t});
         for (i = 0; i < len; i += 2) begin
            last_word = (i + 2 >= len);
            // Lone last sample fills both halves
            if (i + 1 < len)
               exp_q.push_back({last_word, smp_q[pos+i], smp_q[pos+i+1]});
            else
               exp_q.push_back({1'b1, smp_q[pos+i], smp_q[pos+i]});
         end
         seq = eob ? '0 : seq + 1'b1;
         pos += len;
         rem -= len;
         new_burst = (burst_size != 0) && (rem == 0);
         if (new_burst)
            rem = int'(burst_size);
      end
   endtask

   // ------------------------------
   // Stream driver and collector
   // ------------------------------
   // Valid holds until the beat is taken
   task automatic send_samples();
      int   i;
      logic took;
      i = 0;
      took = 1'b0;
      while (i < smp_q.size()) begin
         @(negedge clk);
         if (took)
            in_valid = 1'b0;
         if (!in_valid)
            in_valid = ($urandom_range(99) < in_density);
         in_data = smp_q[i];
         #1;
         took = in_valid && in_ready;
         if (took)
            i++;
      end
      @(negedge clk);
      in_valid = 1'b0;
   endtask

   // Ready forced high once all expected words are in, to expose extras
   task automatic collect_words();
      logic [WORD_W:0] got;
      logic [WORD_W:0] exp;
      int              n;
      int              quiet;
      n = 0;
      quiet = 0;
      while (quiet < DRAIN_CYCLES) begin
         @(negedge clk);
         out_ready = (exp_q.size() == 0) || ($urandom_range(99) < out_density);
         #1;
         if (exp_q.size() == 0)
            quiet++;
         if (out_valid && out_ready) begin
            got = {out_last, out_data};
            checks++;
            assert (exp_q.size() != 0) else begin
               $display("%s: extra output word %0d (%h) after the last packet",
                        test_name, n, got);
               test_errors++;
            end
            if (exp_q.size() != 0) begin
               exp = exp_q.pop_front();
               assert (got == exp) else begin
                  $display("[FAIL] %s word %0d: expected %h, actual %h",
                           test_name, n, exp, got);
                  test_errors++;
               end
            end
            n++;
         end
      end
   endtask

   task automatic run_traffic();
      build_expected();
      fork
         send_samples();
         collect_words();
      join
   endtask

   // ------------------------------
   // Test setup and bookkeeping
   // ------------------------------
   task automatic configure(input string name, input int psize, input int bsize,
                            input int in_pct, input int out_pct);
      @(negedge clk);
      enable = 1'b0;
      test_name = name;
      test_errors = 0;
      packet_size = SIZE_W'(psize);
      burst_size = BURST_W'(bsize);
      start_time = {$urandom, $urandom};
      time_per_pkt = INC_W'($urandom);
      flow_id = $urandom;
      in_density = in_pct;
      out_density = out_pct;
      // Framer passes through flush while disabled
      repeat (4) @(negedge clk);
      enable = 1'b1;
   endtask

   task automatic make_samples(input int n);
      smp_q.delete();
      repeat (n) smp_q.push_back($urandom);
   endtask

   task automatic finish_test();
      tests_run++;
      errors += test_errors;
      if (test_errors == 0) begin
         $display("test %s: ok", test_name);
      end else begin
         tests_failed++;
         $display("test %s: %0d errors", test_name, test_errors);
      end
   endtask

   // ------------------------------
   // Directed tests
   // ------------------------------
   task automatic check_reset_state();
      test_name = "reset_state";
      test_errors = 0;
      checks += 3;
      assert (idle == 1'b1) else begin
         $display("[FAIL] %s idle: expected 1, actual %b", test_name, idle);
         test_errors++;
      end
      assert (out_valid == 1'b0) else begin
         $display("[FAIL] %s out_valid: expected 0, actual %b", test_name, out_valid);
         test_errors++;
      end
      assert (in_ready == 1'b0) else begin
         $display("[FAIL] %s in_ready: expected 0, actual %b", test_name, in_ready);
         test_errors++;
      end
      finish_test();
   endtask

   task automatic test_even_packet();
      configure("even_packet", 8, 0, 100, 100);
      make_samples(8);
      run_traffic();
      finish_test();
   endtask

   // Two odd packets cover the time increment too
   task automatic test_odd_packet();
      configure("odd_packet", 5, 0, 100, 100);
      make_samples(10);
      run_traffic();
      finish_test();
   endtask

   // Two bursts of 4, 4 and 3 samples
   task automatic test_burst_eob();
      configure("burst_eob", 4, 11, 100, 100);
      make_samples(22);
      run_traffic();
      finish_test();
   endtask

   task automatic test_backpressure();
      configure("backpressure", 7, 20, 50, 40);
      make_samples(40);
      run_traffic();
      finish_test();
   endtask

   // Disable with one whole packet still held at the output
   task automatic test_disable_idle();
      int n;
      configure("disable_idle", 6, 0, 100, 100);
      make_samples(6);
      build_expected();
      out_ready = 1'b0;
      send_samples();
      @(negedge clk);
      enable = 1'b0;
      repeat (4) @(negedge clk);
      checks++;
      assert (idle == 1'b0) else begin
         $display("[FAIL] %s idle with output pending: expected 0, actual %b",
                  test_name, idle);
         test_errors++;
      end
      // Framer finishes the held packet before it flushes
      collect_words();
      n = 0;
      while (!idle && n < 20) begin
         @(negedge clk);
         n++;
      end
      checks++;
      assert (idle) else begin
         $display("%s: idle did not rise after disable with the output drained", test_name);
         test_errors++;
      end
      // Model restarts at seq 0 and start_time after re-enable
      repeat (2) @(negedge clk);
      enable = 1'b1;
      make_samples(12);
      run_traffic();
      checks++;
      assert (idle == 1'b0) else begin
         $display("[FAIL] %s idle while enabled: expected 0, actual %b", test_name, idle);
         test_errors++;
      end
      finish_test();
   endtask

   // ------------------------------
   // Run control
   // ------------------------------
   initial begin
      cycles = 0;
      while (cycles < TIMEOUT_CYCLES) begin
         @(posedge clk);
         cycles++;
      end
      $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Result: FAILED");
      $finish;
   end

   initial begin
      void'($urandom(32'hafe44e49));
      in_data = '0;
      in_valid = 1'b0;
      out_ready = 1'b0;
      enable = 1'b0;
      start_time = '0;
      packet_size = SIZE_W'(1);
      flow_id = '0;
      time_per_pkt = '0;
      burst_size = '0;
      errors = 0;
      checks = 0;
      tests_run = 0;
      tests_failed = 0;
      wait (rst == 1'b0);
      @(negedge clk);
      check_reset_state();
      test_even_packet();
      test_odd_packet();
      test_burst_eob();
      test_backpressure();
      test_disable_idle();
      $display("tests %0d, failed %0d, checks %0d, errors %0d",
               tests_run, tests_failed, checks, errors);
      if (errors == 0)
         $display("Result: PASSED");
      else
         $display("Result: FAILED");
      $finish;
   end

endmodule

// File: tb/tb_clock.sv
/*
 Testbench clock, 8 ns period.
 rst is high for two rising edges, released on a falling edge.
*/
`timescale 1ns/10ps

module tb_clock (
   output logic clk,
   output logic rst
);

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   // Release away from the active edge
   initial begin
      rst = 1'b1;
      repeat (2) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;
   end

endmodule
